/* common/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // ####################
  // Data and status widths
  // ####################

  localparam int WORD_W   = 32;
  localparam int STATUS_W = 6;

  typedef logic [WORD_W-1:0]   word_t;    // General register and operand word
  typedef logic [STATUS_W-1:0] status_t;  // Flag register with bits at the FLAG_* positions

  // Bit positions inside status_t
  localparam int FLAG_CF = 0;  // Carry out of bit 31 or borrow for subtract
  localparam int FLAG_PF = 1;  // Even number of ones in the result
  localparam int FLAG_AF = 2;  // Carry out of bit 3
  localparam int FLAG_ZF = 3;  // Result is zero
  localparam int FLAG_SF = 4;  // Top bit of the result
  localparam int FLAG_OF = 5;  // Signed overflow

  // ####################
  // ALU control word
  // ####################

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    MUL = 3'd5,
    DIV = 3'd6
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;         // Operation select
    logic    src_inv;    // Invert operand 1 before use
    logic    src_inc;    // Force the carry input to one
    logic    use_carry;  // Feed the incoming CF into the carry input
    logic    clear_cf;   // Force CF low in the new status
    logic    clear_of;   // Force OF low in the new status
    logic    no_wr;      // Keep the destination, update status only
  } alu_cntl_t;

endpackage

`default_nettype wire

/* common/regs_pkg.sv */
`default_nettype none

package regs_pkg;

  localparam int NUM_REGS = 8;

  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // Command word in the low bits of the command register
  typedef struct packed {
    alu_pkg::alu_cntl_t cntl;
    reg_idx_t           dst;
    reg_idx_t           src0;
    reg_idx_t           src1;
  } cmd_t;

  // ####################
  // APB transport
  // ####################

  typedef logic [5:0] apb_addr_t;  // Byte address

  typedef struct packed {
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_addr_t      paddr;
    alu_pkg::word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    alu_pkg::word_t prdata;
    logic           pready;
    logic           pslverr;
  } apb_rsp_t;

  // Address map
  localparam apb_addr_t ADDR_GPR_BASE = 6'h00;  // Eight registers in steps of 4
  localparam apb_addr_t ADDR_STATUS   = 6'h20;
  localparam apb_addr_t ADDR_CMD      = 6'h24;

endpackage

`default_nettype wire

/* design/alu.sv */
`default_nettype none

module alu (
  input  alu_pkg::alu_cntl_t cntl,
  input  alu_pkg::status_t   status_in,
  input  alu_pkg::word_t     opnd0,
  input  alu_pkg::word_t     opnd1,
  output alu_pkg::status_t   status_out,
  output alu_pkg::word_t     result,
  output logic               div_zero
);

  import alu_pkg::*;

  word_t       opnd1_eff;
  logic        carry_in;
  logic [32:0] sum;
  logic [32:0] diff;
  logic [32:0] diff_sx;
  logic [63:0] product;
  logic        divisor_zero;
  word_t       quotient;
  logic        cf;
  logic        of;
  logic        af;

  // ####################
  // Operand preparation
  // ####################

  assign opnd1_eff = cntl.src_inv ? ~opnd1 : opnd1;
  assign carry_in  = cntl.src_inc | (cntl.use_carry & status_in[FLAG_CF]);

  assign sum     = {1'b0, opnd0} + {1'b0, opnd1_eff} + {32'b0, carry_in};
  assign diff    = {1'b0, opnd0} - {1'b0, opnd1_eff} + {32'b0, carry_in};  // Bit 32 is the borrow
  assign product = {32'b0, opnd0} * {32'b0, opnd1_eff};

  // Signed difference one bit wider, its top two bits differ on overflow
  assign diff_sx = {opnd0[31], opnd0} - {opnd1_eff[31], opnd1_eff} + {32'b0, carry_in};

  assign divisor_zero = (opnd1_eff == '0);
  assign quotient     = divisor_zero ? '1 : opnd0 / opnd1_eff;  // All ones on a zero divisor
  assign div_zero     = (cntl.op == DIV) && divisor_zero;

  // ####################
  // Result select
  // ####################

  always_comb begin
    result = '0;
    cf     = 1'b0;
    of     = 1'b0;
    af     = 1'b0;
    case (cntl.op)
      ADD: begin
        result = sum[31:0];
        cf     = sum[32];
        af     = opnd0[4] ^ opnd1_eff[4] ^ sum[4];  // Carry into bit 4
        of     = (opnd0[31] == opnd1_eff[31]) && (sum[31] != opnd0[31]);
      end
      SUB: begin
        result = diff[31:0];
        cf     = diff[32];
        af     = opnd0[4] ^ opnd1_eff[4] ^ diff[4];  // Borrow into bit 4
        of     = diff_sx[32] ^ diff_sx[31];
      end
      AND: result = opnd0 & opnd1_eff;
      OR:  result = opnd0 | opnd1_eff;
      XOR: result = opnd0 ^ opnd1_eff;
      MUL: begin
        result = product[31:0];
        cf     = |product[63:32];  // Product did not fit in one word
        of     = |product[63:32];
      end
      DIV: result = quotient;  // Unsigned quotient with CF and OF low
      default: result = '0;
    endcase
  end

  always_comb begin
    status_out          = '0;
    status_out[FLAG_CF] = cf & ~cntl.clear_cf;
    status_out[FLAG_PF] = ~^result;
    status_out[FLAG_AF] = af;
    status_out[FLAG_ZF] = (result == '0);
    status_out[FLAG_SF] = result[31];
    status_out[FLAG_OF] = of & ~cntl.clear_of;
  end

endmodule

`default_nettype wire

/* execute/reg_file.sv */
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  regs_pkg::reg_idx_t waddr,
  input  alu_pkg::word_t    wdata,
  input  regs_pkg::reg_idx_t raddr0,
  input  regs_pkg::reg_idx_t raddr1,
  output alu_pkg::word_t    rdata0,
  output alu_pkg::word_t    rdata1
);

  import alu_pkg::*;
  import regs_pkg::*;

  word_t regs [NUM_REGS];

  // ####################
  // Write port
  // ####################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // ####################
  // Read ports
  // ####################

  // Reads see the old value during a write cycle
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

endmodule

`default_nettype wire

/* execute/execute.sv */
`default_nettype none

module execute (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue,
  input  regs_pkg::cmd_t     cmd,
  input  logic               gpr_we,
  input  regs_pkg::reg_idx_t gpr_idx,
  input  alu_pkg::word_t     gpr_wdata,
  input  logic               status_we,
  input  alu_pkg::status_t   status_wdata,
  output alu_pkg::word_t     gpr_rdata,
  output alu_pkg::status_t   status,
  output logic               done,
  output logic               div_zero
);

  import alu_pkg::*;
  import regs_pkg::*;

  logic     rf_we;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;
  reg_idx_t rf_raddr0;
  reg_idx_t rf_raddr1;
  word_t    rf_rdata0;
  word_t    rf_rdata1;
  word_t    alu_result;
  status_t  alu_status;
  logic     alu_div_zero;

  // ####################
  // Register file port sharing
  // ####################

  assign rf_raddr0 = issue ? cmd.src0 : gpr_idx;  // Bus reads use port 0
  assign rf_raddr1 = issue ? cmd.src1 : gpr_idx;
  assign rf_we     = issue ? ~cmd.cntl.no_wr : gpr_we;  // no_wr turns a command into a compare
  assign rf_waddr  = issue ? cmd.dst : gpr_idx;
  assign rf_wdata  = issue ? alu_result : gpr_wdata;

  assign gpr_rdata = rf_rdata0;

  reg_file i_reg_file (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .raddr0 (rf_raddr0),
    .raddr1 (rf_raddr1),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1)
  );

  alu i_alu (
    .cntl       (cmd.cntl),
    .status_in  (status),
    .opnd0      (rf_rdata0),
    .opnd1      (rf_rdata1),
    .status_out (alu_status),
    .result     (alu_result),
    .div_zero   (alu_div_zero)
  );

  // ####################
  // Status and completion
  // ####################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status   <= '0;
      done     <= 1'b0;
      div_zero <= 1'b0;
    end else begin
      if (issue) begin
        status <= alu_status;  // Flags update even when no_wr is set
      end else if (status_we) begin
        status <= status_wdata;
      end
      done     <= issue;
      div_zero <= issue & alu_div_zero;
    end
  end

endmodule

`default_nettype wire

/* design/apb_exec_regs.sv */
`default_nettype none

module apb_exec_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  regs_pkg::apb_req_t apb_req,
  input  alu_pkg::word_t     gpr_rdata,
  input  alu_pkg::status_t   status,
  input  logic               done,
  input  logic               div_zero,
  output regs_pkg::apb_rsp_t apb_rsp,
  output logic               gpr_we,
  output regs_pkg::reg_idx_t gpr_idx,
  output alu_pkg::word_t     gpr_wdata,
  output logic               status_we,
  output alu_pkg::status_t   status_wdata,
  output logic               issue,
  output regs_pkg::cmd_t     cmd
);

  import alu_pkg::*;
  import regs_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT_EXEC
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   access;
  logic   is_gpr;
  logic   is_status;
  logic   is_cmd;
  logic   unmapped;

  // ####################
  // Address decode
  // ####################

  assign access = apb_req.psel & apb_req.penable;

  // Word aligned addresses below 0x20 hit the general registers
  assign is_gpr    = ({apb_req.paddr[5], apb_req.paddr[1:0]} ==
                      {ADDR_GPR_BASE[5], ADDR_GPR_BASE[1:0]});
  assign is_status = (apb_req.paddr == ADDR_STATUS);
  assign is_cmd    = (apb_req.paddr == ADDR_CMD);
  assign unmapped  = ~(is_gpr | is_status | is_cmd);

  // ####################
  // Execute side strobes
  // ####################

  assign gpr_idx      = apb_req.paddr[4:2];
  assign gpr_wdata    = apb_req.pwdata;
  assign gpr_we       = access & apb_req.pwrite & is_gpr;
  assign status_wdata = apb_req.pwdata[$bits(status_t)-1:0];
  assign status_we    = access & apb_req.pwrite & is_status;
  assign cmd          = cmd_t'(apb_req.pwdata[$bits(cmd_t)-1:0]);

  // Only the first access cycle of a command write starts the execute block
  assign issue = access & apb_req.pwrite & is_cmd & (state == IDLE);

  // ####################
  // Command pacing FSM
  // ####################

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      if (issue) state_nxt = WAIT_EXEC;
      WAIT_EXEC: if (done) state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ####################
  // Response
  // ####################

  always_comb begin
    apb_rsp = '0;
    if (access && !apb_req.pwrite) begin
      if (is_gpr) begin
        apb_rsp.prdata = gpr_rdata;
      end else if (is_status) begin
        apb_rsp.prdata = word_t'(status);  // Upper bits read as zero
      end
    end
    if (state == WAIT_EXEC) begin
      apb_rsp.pready  = access & done;  // Second access cycle of a command
      apb_rsp.pslverr = access & done & div_zero;
    end else if (access && !issue) begin
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = unmapped;
    end
  end

endmodule

`default_nettype wire

/* design/exec_unit_top.sv */
`default_nettype none

module exec_unit_top (
  input  logic               clk,
  input  logic               rst_n,
  input  regs_pkg::apb_req_t apb_req,
  output regs_pkg::apb_rsp_t apb_rsp
);

  import alu_pkg::*;
  import regs_pkg::*;

  logic     gpr_we;
  reg_idx_t gpr_idx;
  word_t    gpr_wdata;
  word_t    gpr_rdata;
  logic     status_we;
  status_t  status_wdata;
  status_t  status;
  logic     issue;
  cmd_t     cmd;
  logic     done;
  logic     div_zero;

  apb_exec_regs i_apb_exec_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb_req      (apb_req),
    .gpr_rdata    (gpr_rdata),
    .status       (status),
    .done         (done),
    .div_zero     (div_zero),
    .apb_rsp      (apb_rsp),
    .gpr_we       (gpr_we),
    .gpr_idx      (gpr_idx),
    .gpr_wdata    (gpr_wdata),
    .status_we    (status_we),
    .status_wdata (status_wdata),
    .issue        (issue),
    .cmd          (cmd)
  );

  execute i_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .cmd          (cmd),
    .gpr_we       (gpr_we),
    .gpr_idx      (gpr_idx),
    .gpr_wdata    (gpr_wdata),
    .status_we    (status_we),
    .status_wdata (status_wdata),
    .gpr_rdata    (gpr_rdata),
    .status       (status),
    .done         (done),
    .div_zero     (div_zero)
  );

endmodule

`default_nettype wire

/* test/exec_unit_props.sv */
`default_nettype none

module exec_unit_props (
  input logic               clk,
  input logic               rst_n,
  input regs_pkg::apb_req_t apb_req,
  input regs_pkg::apb_rsp_t apb_rsp,
  input logic               issue,
  input logic               done
);

  // ####################
  // APB response rules
  // ####################

  pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else $error("pready was raised outside the access phase");

  pslverr_with_pready: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pslverr |-> apb_rsp.pready)
    else $error("pslverr was raised without pready");

  // ####################
  // Issue and completion
  // ####################

  issue_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    issue |=> !issue)
    else $error("issue stayed high for more than one cycle");

  done_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    issue |=> done)
    else $error("done did not follow issue after one cycle");

  done_only_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(issue))
    else $error("done appeared without an issue in the cycle before");

endmodule

bind apb_exec_regs exec_unit_props i_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .issue   (issue),
  .done    (done)
);

`default_nettype wire

/* test/exec_unit_checker.sv */
`default_nettype none

module exec_unit_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  regs_pkg::apb_req_t apb_req,
  input  regs_pkg::apb_rsp_t apb_rsp,
  input  logic               cmd_err_expected,
  output int                 value_errors,
  output int                 timing_errors
);

  import alu_pkg::*;
  import regs_pkg::*;

  localparam longint S_MAX = 64'sh0000_0000_7FFF_FFFF;
  localparam longint S_MIN = -64'sh0000_0000_8000_0000;

  word_t   model_regs [NUM_REGS];  // Shadow copy built from observed writes
  status_t model_status;
  int      access_cycles;

  function automatic logic out_of_range(input longint v, input longint lo, input longint hi);
    return (v < lo) || (v > hi);
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t got);
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
      value_errors++;
    end
  endtask

  // ####################
  // Reference ALU
  // ####################

  task automatic run_command(input cmd_t c, output logic dz);
    word_t       a;
    word_t       b;
    word_t       res;
    logic        cin;
    logic        cf;
    logic        of;
    logic        af;
    longint      u;
    longint      s;
    int          nib;
    logic [63:0] prod;
    status_t     st;
    a   = model_regs[c.src0];
    b   = c.cntl.src_inv ? ~model_regs[c.src1] : model_regs[c.src1];
    cin = c.cntl.src_inc | (c.cntl.use_carry & model_status[FLAG_CF]);
    res = '0;
    cf  = 1'b0;
    of  = 1'b0;
    af  = 1'b0;
    dz  = 1'b0;
    case (c.cntl.op)
      ADD, SUB: begin
        if (c.cntl.op == ADD) begin
          u   = longint'({32'b0, a}) + longint'({32'b0, b}) + longint'(cin);
          s   = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
          nib = int'(a[3:0]) + int'(b[3:0]) + int'(cin);
        end else begin
          u   = longint'({32'b0, a}) - longint'({32'b0, b}) + longint'(cin);
          s   = longint'($signed(a)) - longint'($signed(b)) + longint'(cin);
          nib = int'(a[3:0]) - int'(b[3:0]) + int'(cin);
        end
        res = u[31:0];
        cf  = out_of_range(u, 0, 64'h0000_0000_FFFF_FFFF);  // Carry or borrow past bit 31
        of  = out_of_range(s, S_MIN, S_MAX);
        af  = out_of_range(longint'(nib), 0, 15);  // Low nibble carried or borrowed
      end
      AND: res = a & b;
      OR:  res = a | b;
      XOR: res = a ^ b;
      MUL: begin
        prod = {32'b0, a} * {32'b0, b};
        res  = prod[31:0];
        cf   = (prod[63:32] != '0);
        of   = (prod[63:32] != '0);
      end
      DIV: begin
        dz  = (b == '0);
        res = dz ? '1 : a / b;
      end
      default: res = '0;
    endcase
    st          = '0;
    st[FLAG_CF] = cf & ~c.cntl.clear_cf;
    st[FLAG_PF] = ($countones(res) % 2) == 0;
    st[FLAG_AF] = af;
    st[FLAG_ZF] = (res == '0);
    st[FLAG_SF] = res[31];
    st[FLAG_OF] = of & ~c.cntl.clear_of;
    if (!c.cntl.no_wr) begin
      model_regs[c.dst] = res;
    end
    model_status = st;
  endtask

  // ####################
  // Transfer completion
  // ####################

  task automatic finish_transfer();
    apb_addr_t addr;
    logic      is_gpr;
    logic      is_status;
    logic      is_cmd;
    logic      exp_err;
    logic      dz;
    int        exp_cycles;
    word_t     exp_rdata;
    addr       = apb_req.paddr;
    is_gpr     = (addr < ADDR_STATUS) && (addr[1:0] == 2'b00);
    is_status  = (addr == ADDR_STATUS);
    is_cmd     = (addr == ADDR_CMD);
    exp_err    = !(is_gpr || is_status || is_cmd);  // Unmapped addresses answer with an error
    exp_cycles = 1;
    if (apb_req.pwrite) begin
      if (is_gpr) begin
        model_regs[addr[4:2]] = apb_req.pwdata;
      end else if (is_status) begin
        model_status = apb_req.pwdata[5:0];
      end else if (is_cmd) begin
        run_command(cmd_t'(apb_req.pwdata[$bits(cmd_t)-1:0]), dz);
        exp_err    = dz;
        exp_cycles = 2;
        compare_word("pslverr against table", word_t'(cmd_err_expected),
                     word_t'(apb_rsp.pslverr));
      end
    end else begin
      exp_rdata = '0;
      if (is_gpr) begin
        exp_rdata = model_regs[addr[4:2]];
      end else if (is_status) begin
        exp_rdata = word_t'(model_status);
      end
      compare_word($sformatf("prdata at 0x%h", addr), exp_rdata, apb_rsp.prdata);
    end
    compare_word($sformatf("pslverr at 0x%h", addr), word_t'(exp_err), word_t'(apb_rsp.pslverr));
    if (access_cycles != exp_cycles) begin
      $display("Transfer at address 0x%h took %0d access cycles instead of %0d",
               addr, access_cycles, exp_cycles);
      timing_errors++;
    end
  endtask

  // Mid-cycle sampling keeps clear of the edge where the driver updates
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
      model_status  = '0;
      access_cycles = 0;
    end else if (apb_req.psel && apb_req.penable) begin
      access_cycles++;
      if (apb_rsp.pready) begin
        finish_transfer();
        access_cycles = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* test/exec_unit_top_tb.sv */
`default_nettype none

module exec_unit_top_tb;

  import alu_pkg::*;
  import regs_pkg::*;

  localparam int NUM_ROWS   = 27;
  localparam int WAIT_LIMIT = 20;  // Cycles allowed for pready

  // Control modifier bits in the order {src_inv, src_inc, use_carry, clear_cf, clear_of, no_wr}
  localparam logic [5:0] F_NONE = 6'b000000;
  localparam logic [5:0] F_INV  = 6'b100000;
  localparam logic [5:0] F_INC  = 6'b010000;
  localparam logic [5:0] F_CRY  = 6'b001000;
  localparam logic [5:0] F_CCF  = 6'b000100;
  localparam logic [5:0] F_COF  = 6'b000010;
  localparam logic [5:0] F_NWR  = 6'b000001;

  typedef struct packed {
    logic    rand_ops;   // Replace both source values with random words
    word_t   val0;
    word_t   val1;
    cmd_t    cmd;
    status_t status_in;  // Status loaded before the command
    logic    exp_err;    // Command must end with pslverr
  } row_t;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     cmd_err_expected;
  logic     timed_out;
  int       value_errors;
  int       timing_errors;
  row_t     rows [NUM_ROWS];
  word_t    rdata;
  word_t    v0;
  word_t    v1;

  exec_unit_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  exec_unit_checker i_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .apb_req          (apb_req),
    .apb_rsp          (apb_rsp),
    .cmd_err_expected (cmd_err_expected),
    .value_errors     (value_errors),
    .timing_errors    (timing_errors)
  );

  always #50 clk = ~clk;

  function automatic row_t make_row(input logic rnd, input word_t a, input word_t b,
                                    input alu_op_e op, input logic [5:0] fl, input reg_idx_t d,
                                    input reg_idx_t s0, input reg_idx_t s1, input status_t st,
                                    input logic err);
    row_t r;
    r.rand_ops  = rnd;
    r.val0      = a;
    r.val1      = b;
    r.cmd.cntl  = alu_cntl_t'({op, fl});
    r.cmd.dst   = d;
    r.cmd.src0  = s0;
    r.cmd.src1  = s1;
    r.status_in = st;
    r.exp_err   = err;
    return r;
  endfunction

  function automatic apb_addr_t gpr_addr(input reg_idx_t idx);
    return ADDR_GPR_BASE + apb_addr_t'({idx, 2'b00});
  endfunction

  // ####################
  // APB master
  // ####################

  task automatic apb_transfer(input logic write, input apb_addr_t addr, input word_t wdata,
                              output word_t data);
    int waited;
    data = '0;
    if (!timed_out) begin
      @(posedge clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(posedge clk);
      apb_req.penable <= 1'b1;  // Access phase
      waited = 0;
      @(negedge clk);
      while (!apb_rsp.pready && waited < WAIT_LIMIT) begin
        waited++;
        @(negedge clk);
      end
      if (apb_rsp.pready) begin
        data = apb_rsp.prdata;
      end else begin
        $display("Timeout: no pready within %0d cycles at address 0x%h", WAIT_LIMIT, addr);
        timed_out = 1'b1;
      end
      @(posedge clk);
      apb_req <= '0;
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input word_t data);
    word_t unused_rdata;
    apb_transfer(1'b1, addr, data, unused_rdata);
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data);
    apb_transfer(1'b0, addr, '0, data);
  endtask

  initial begin
    clk              = 1'b0;
    rst_n            <= 1'b0;
    apb_req          <= '0;
    cmd_err_expected = 1'b0;
    timed_out        = 1'b0;
    void'($urandom(32'h609e_9a7d));

    rows[0]  = make_row(1'b1, 32'h0, 32'h0, ADD, F_NONE, 3'd2, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[1]  = make_row(1'b0, 32'h7FFF_FFFF, 32'h1, ADD, F_NONE, 3'd3, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[2]  = make_row(1'b0, 32'hFFFF_FFFF, 32'h1, ADD, F_NONE, 3'd3, 3'd1, 3'd2, 6'h00, 1'b0);
    rows[3]  = make_row(1'b0, 32'h0000_000F, 32'h1, ADD, F_NONE, 3'd4, 3'd5, 3'd6, 6'h00, 1'b0);
    rows[4]  = make_row(1'b1, 32'h0, 32'h0, ADD, F_CRY, 3'd2, 3'd0, 3'd1, 6'h01, 1'b0);
    rows[5]  = make_row(1'b1, 32'h0, 32'h0, ADD, F_INV | F_INC, 3'd7, 3'd3, 3'd4, 6'h00, 1'b0);
    rows[6]  = make_row(1'b1, 32'h0, 32'h0, SUB, F_NONE, 3'd2, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[7]  = make_row(1'b0, 32'h0, 32'h1, SUB, F_NONE, 3'd3, 3'd4, 3'd5, 6'h00, 1'b0);
    rows[8]  = make_row(1'b0, 32'h8000_0000, 32'h1, SUB, F_NONE, 3'd6, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[9]  = make_row(1'b1, 32'h0, 32'h0, SUB, F_INC, 3'd5, 3'd2, 3'd3, 6'h00, 1'b0);
    rows[10] = make_row(1'b1, 32'h0, 32'h0, AND, F_NONE, 3'd1, 3'd2, 3'd3, 6'h3F, 1'b0);
    rows[11] = make_row(1'b1, 32'h0, 32'h0, OR, F_NONE, 3'd0, 3'd6, 3'd7, 6'h25, 1'b0);
    rows[12] = make_row(1'b0, 32'h1234_5678, 32'h1234_5678, XOR, F_NONE, 3'd4, 3'd1, 3'd2,
                        6'h00, 1'b0);
    rows[13] = make_row(1'b1, 32'h0, 32'h0, AND, F_INV, 3'd5, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[14] = make_row(1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, ADD, F_CCF | F_COF, 3'd2, 3'd0,
                        3'd1, 6'h00, 1'b0);
    rows[15] = make_row(1'b0, 32'h7FFF_FFFF, 32'h7FFF_FFFF, ADD, F_COF, 3'd3, 3'd0, 3'd1,
                        6'h00, 1'b0);
    rows[16] = make_row(1'b0, 32'h0000_FFFF, 32'h0000_FFFF, MUL, F_NONE, 3'd4, 3'd0, 3'd1,
                        6'h00, 1'b0);
    rows[17] = make_row(1'b0, 32'h0001_0000, 32'h0001_0000, MUL, F_NONE, 3'd5, 3'd0, 3'd1,
                        6'h00, 1'b0);
    rows[18] = make_row(1'b1, 32'h0, 32'h0, MUL, F_NONE, 3'd6, 3'd2, 3'd3, 6'h00, 1'b0);
    rows[19] = make_row(1'b1, 32'h0, 32'h0, DIV, F_NONE, 3'd7, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[20] = make_row(1'b0, 32'd100, 32'd7, DIV, F_NONE, 3'd2, 3'd3, 3'd4, 6'h00, 1'b0);
    rows[21] = make_row(1'b0, 32'h1234_5678, 32'h0, DIV, F_NONE, 3'd3, 3'd0, 3'd1, 6'h00, 1'b1);
    rows[22] = make_row(1'b0, 32'h10, 32'hFFFF_FFFF, DIV, F_INV, 3'd4, 3'd0, 3'd1, 6'h00, 1'b1);
    rows[23] = make_row(1'b1, 32'h0, 32'h0, SUB, F_NWR, 3'd7, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[24] = make_row(1'b1, 32'h0, 32'h0, ADD, F_NWR | F_CRY, 3'd6, 3'd1, 3'd2, 6'h01, 1'b0);
    // Carry input pushes a subtract across the signed limits
    rows[25] = make_row(1'b0, 32'h7FFF_FFFF, 32'h0, SUB, F_INC, 3'd2, 3'd0, 3'd1, 6'h00, 1'b0);
    rows[26] = make_row(1'b0, 32'hFFFF_FFFF, 32'h0, SUB, F_INC, 3'd3, 3'd4, 3'd5, 6'h00, 1'b0);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // ####################
    // Direct register access
    // ####################

    for (int r = 0; r < NUM_REGS; r++) begin
      apb_write(gpr_addr(reg_idx_t'(r)), $urandom());
    end
    for (int r = 0; r < NUM_REGS; r++) begin
      apb_read(gpr_addr(reg_idx_t'(r)), rdata);
    end
    apb_write(ADDR_STATUS, 32'hFFFF_FFFF);  // Only six bits stick
    apb_read(ADDR_STATUS, rdata);
    apb_write(ADDR_STATUS, 32'h0000_0015);
    apb_read(ADDR_STATUS, rdata);
    apb_read(6'h28, rdata);
    apb_read(6'h3C, rdata);
    apb_read(6'h06, rdata);  // Misaligned register address
    apb_write(6'h2C, 32'hDEAD_BEEF);

    // ####################
    // Command table
    // ####################

    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      v0 = rows[i].rand_ops ? $urandom() : rows[i].val0;
      v1 = rows[i].rand_ops ? $urandom() : rows[i].val1;
      apb_write(gpr_addr(rows[i].cmd.src0), v0);
      apb_write(gpr_addr(rows[i].cmd.src1), v1);
      apb_write(ADDR_STATUS, word_t'(rows[i].status_in));
      cmd_err_expected = rows[i].exp_err;
      apb_write(ADDR_CMD, word_t'(rows[i].cmd));
      apb_read(gpr_addr(rows[i].cmd.dst), rdata);
      apb_read(ADDR_STATUS, rdata);
    end

    repeat (2) @(posedge clk);
    $display("Error counts: value %0d, timing %0d, timeout %0d",
             value_errors, timing_errors, timed_out ? 1 : 0);
    if (timed_out || value_errors != 0 || timing_errors != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* exec_unit_top.f */
common/alu_pkg.sv
common/regs_pkg.sv
design/alu.sv
execute/reg_file.sv
execute/execute.sv
design/apb_exec_regs.sv
design/exec_unit_top.sv
test/exec_unit_props.sv
test/exec_unit_checker.sv
test/exec_unit_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_unit_top_tb \
  -f exec_unit_top.f \
  -o exec_unit_sim

./obj_dir/exec_unit_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run reported a failure, see sim.log"
  exit 1
fi

echo "Run finished without a reported failure"
